// ==== dv/theiaCoreTb.sv ====
//--------------------------------------------------------------------------
// Self-checking testbench for the shader core, inputs change on falling edges
// Expected values come from lane math done here, modulo 2^32
// Every wait is a bounded loop, a lost ack or commit counts as an error
//--------------------------------------------------------------------------
`timescale 1ns/10ps

module theiaCoreTb;

  localparam int waitLimit = 2000;                  // Cycles per bounded wait

  logic        clock = 1'b0;
  logic        rstN;
  logic        mst, weI, stbI, cycI;
  logic [31:0] datI, datO;
  logic [15:0] adrI, controlReg;
  logic [1:0]  tgaI;
  logic        ackO, renderEn, sceneDone, rCommit, done;
  logic [31:0] omemDat, omemAdr;
  logic        omemWe;

  logic [31:0] lfsrState = 32'hf92d9a7e;
  int          errors = 0;
  int          testsRun = 0;
  int          testsFailed = 0;
  int          errorsAtStart = 0;
  int          commitCount = 0;
  int          omemCount = 0;
  logic [31:0] expOutAddr [$];                      // Pending OUT writes, in order
  logic [31:0] expOutData [$];

  theiaCore theiaCore_inst (.*);

  always #10 clock = ~clock;                        // 20 ns period

  //------------------------------------------------------------------------
  // Helpers
  //------------------------------------------------------------------------
  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] randomBits(input int count);
    logic [31:0] value;
    logic        outBit;
    value = '0;
    for (int i = 0; i < count; i++) begin
      outBit    = lfsrState[0];
      lfsrState = lfsrState >> 1;
      if (outBit) lfsrState = lfsrState ^ 32'hd0000001;
      value = {value[30:0], outBit};
    end
    return value;
  endfunction

  function automatic logic [31:0] encodeInstr(input theiaPkg::opcodeT op,
                                              input logic [7:0] dst, srcA, srcB);
    return {op, dst, srcA, srcB, 4'h0};             // Low nibble unused
  endfunction

  task automatic checkEqual(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    assert (actual === expected) else begin
      errors++;
      $display("** Error at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic waitCycles(input int count);
    repeat (count) @(negedge clock);
  endtask

  task automatic beginTest();
    errorsAtStart = errors;
  endtask

  task automatic finishTest(input string name);
    testsRun++;
    if (errors > errorsAtStart) testsFailed++;
    $display("Test %0d %s: %s", testsRun, name, (errors > errorsAtStart) ? "failed" : "passed");
  endtask

  // One slave transfer, held until ack then dropped
  task automatic busAccess(input logic write, input logic [15:0] adr, input logic [1:0] lane,
                           input logic [31:0] wdata, output logic [31:0] rdata);
    int count;
    @(negedge clock);
    cycI = 1'b1;
    stbI = 1'b1;
    weI  = write;
    adrI = adr;
    tgaI = lane;
    datI = wdata;
    count = 0;
    do begin
      @(negedge clock);
      count++;
    end while (!ackO && count < waitLimit);
    if (!ackO) begin
      errors++;
      $display("Bus access to address %h was never acknowledged", adr);
    end
    rdata = datO;                                   // Valid alongside ack
    cycI = 1'b0;
    stbI = 1'b0;
    weI  = 1'b0;
  endtask

  task automatic writeLane(input logic [7:0] row, input logic [1:0] lane,
                           input logic [31:0] value);
    logic [31:0] unused;
    busAccess(1'b1, {8'h00, row}, lane, value, unused);
  endtask

  task automatic writeCode(input logic [7:0] addr, input logic [31:0] word);
    logic [31:0] unused;
    busAccess(1'b1, {8'h80, addr}, 2'd0, word, unused);  // Bit 15 picks code space
  endtask

  task automatic readCheck(input logic [7:0] row, input logic [1:0] lane,
                           input logic [31:0] expected);
    logic [31:0] value;
    busAccess(1'b0, {8'h00, row}, lane, 32'h0, value);
    checkEqual($sformatf("datO row %0d lane %0d", row, lane), expected, value);
  endtask

  task automatic setMode(input logic hostMode);
    @(negedge clock);
    mst = hostMode;
    waitCycles(2);                                  // FSM moves one cycle later
  endtask

  // Rising renderEn from idle, then wait for the commit pulse
  task automatic runProgram(input logic [7:0] entry, input logic sceneHigh);
    int count;
    int commitsBefore;
    @(negedge clock);
    mst        = 1'b0;
    controlReg = {8'h00, entry};
    sceneDone  = sceneHigh;
    renderEn   = 1'b0;
    waitCycles(2);                                  // Leave CONFIG, clear edge copy
    commitsBefore = commitCount;
    renderEn = 1'b1;
    count = 0;
    do begin
      @(negedge clock);
      count++;
    end while (!rCommit && count < waitLimit);
    if (!rCommit) begin
      errors++;
      $display("Run from entry %h never reached rCommit", entry);
    end
    renderEn = 1'b0;
    waitCycles(4);
    checkEqual("rCommit pulse count", 32'd1, commitCount - commitsBefore);
    if (!sceneHigh) checkEqual("done", 32'd0, done);
  endtask

  //------------------------------------------------------------------------
  // Monitors and assertions
  //------------------------------------------------------------------------
  always @(negedge clock) begin
    if (rCommit) commitCount++;
    if (omemWe) begin
      omemCount++;
      if (expOutAddr.size() == 0) begin
        errors++;
        $display("omemWe pulsed with no output write expected");
      end else begin
        checkEqual("omemAdr", expOutAddr.pop_front(), omemAdr);
        checkEqual("omemDat", expOutData.pop_front(), omemDat);
      end
    end
  end

  commitSingle: assert property (@(posedge clock) disable iff (!rstN) rCommit |=> !rCommit)
    else begin
      errors++;
      $display("rCommit stayed high for more than one cycle");
    end

  doneHeld: assert property (@(posedge clock) disable iff (!rstN) (done && !mst) |=> done)
    else begin
      errors++;
      $display("done dropped while mst was low");
    end

  //------------------------------------------------------------------------
  // Test sequence
  //------------------------------------------------------------------------
  initial begin
    logic [31:0] row [4][3];
    logic [31:0] rowA [3];
    logic [31:0] rowB [3];
    logic [31:0] addrBase;
    int          loops;
    int          count;
    rstN       = 1'b0;
    mst        = 1'b0;
    weI        = 1'b0;
    stbI       = 1'b0;
    cycI       = 1'b0;
    datI       = '0;
    adrI       = '0;
    tgaI       = '0;
    renderEn   = 1'b0;
    sceneDone  = 1'b0;
    controlReg = '0;
    waitCycles(2);
    rstN = 1'b1;

    // Quiet outputs, no ack while mst is low
    beginTest();
    checkEqual("ackO", 32'd0, ackO);
    checkEqual("omemWe", 32'd0, omemWe);
    checkEqual("rCommit", 32'd0, rCommit);
    checkEqual("done", 32'd0, done);
    @(negedge clock);
    cycI = 1'b1;
    stbI = 1'b1;
    weI  = 1'b1;
    adrI = 16'h0005;
    datI = randomBits(32);
    for (int i = 0; i < 8; i++) begin
      @(negedge clock);
      checkEqual("ackO with mst low", 32'd0, ackO);
    end
    cycI = 1'b0;
    stbI = 1'b0;
    weI  = 1'b0;
    finishTest("reset and no ack without mst");

    // Lane writes read back, single lane write leaves neighbours alone
    beginTest();
    setMode(1'b1);
    for (int r = 0; r < 4; r++) begin
      for (int l = 0; l < 3; l++) begin
        row[r][l] = randomBits(32);
        writeLane(8'(40 + r), 2'(l), row[r][l]);
      end
    end
    for (int r = 0; r < 4; r++) begin
      for (int l = 0; l < 3; l++) readCheck(8'(40 + r), 2'(l), row[r][l]);
    end
    row[1][1] = randomBits(32);
    writeLane(8'd41, 2'd1, row[1][1]);
    for (int l = 0; l < 3; l++) readCheck(8'd41, 2'(l), row[1][l]);
    finishTest("configuration write and readback");

    // Lane-wise ALU into rows 20..23
    beginTest();
    for (int l = 0; l < 3; l++) begin
      rowA[l] = randomBits(32);
      rowB[l] = randomBits(32);
      writeLane(8'd10, 2'(l), rowA[l]);
      writeLane(8'd11, 2'(l), rowB[l]);
    end
    writeCode(8'd0, encodeInstr(theiaPkg::OP_ADD, 8'd20, 8'd10, 8'd11));
    writeCode(8'd1, encodeInstr(theiaPkg::OP_SUB, 8'd21, 8'd10, 8'd11));
    writeCode(8'd2, encodeInstr(theiaPkg::OP_AND, 8'd22, 8'd10, 8'd11));
    writeCode(8'd3, encodeInstr(theiaPkg::OP_XOR, 8'd23, 8'd10, 8'd11));
    writeCode(8'd4, encodeInstr(theiaPkg::OP_RET, 8'd0, 8'd0, 8'd0));
    runProgram(8'd0, 1'b0);
    setMode(1'b1);
    for (int l = 0; l < 3; l++) begin
      readCheck(8'd20, 2'(l), 32'(rowA[l] + rowB[l]));     // Wraps at 32 bits
      readCheck(8'd21, 2'(l), 32'(rowA[l] - rowB[l]));
      readCheck(8'd22, 2'(l), rowA[l] & rowB[l]);
      readCheck(8'd23, 2'(l), rowA[l] ^ rowB[l]);
    end
    finishTest("ALU lanes");

    // Counter loop, row 30 counts down, row 31 holds the OUT address
    beginTest();
    loops    = 3 + int'(randomBits(3));
    addrBase = randomBits(32);
    for (int l = 0; l < 3; l++) begin
      writeLane(8'd30, 2'(l), (l == 0) ? 32'(loops) : 32'd0);
      writeLane(8'd31, 2'(l), (l == 0) ? addrBase : 32'd0);
      writeLane(8'd32, 2'(l), 32'd1);
    end
    writeCode(8'd16, encodeInstr(theiaPkg::OP_OUT, 8'd0, 8'd30, 8'd31));
    writeCode(8'd17, encodeInstr(theiaPkg::OP_ADD, 8'd31, 8'd31, 8'd32));
    writeCode(8'd18, encodeInstr(theiaPkg::OP_SUB, 8'd30, 8'd30, 8'd32));
    writeCode(8'd19, encodeInstr(theiaPkg::OP_JNZ, 8'd16, 8'd30, 8'd0));
    writeCode(8'd20, encodeInstr(theiaPkg::OP_RET, 8'd0, 8'd0, 8'd0));
    for (int k = 0; k < loops; k++) begin
      expOutAddr.push_back(32'(addrBase + 32'(k)));
      expOutData.push_back(32'(loops - k));
    end
    count = omemCount;
    runProgram(8'd16, 1'b0);
    checkEqual("omemWe pulse count", 32'(loops), 32'(omemCount - count));
    finishTest("OUT and JNZ loop");

    // Two runs without scene end, then one with it
    beginTest();
    setMode(1'b1);
    writeCode(8'd40, encodeInstr(theiaPkg::OP_RET, 8'd0, 8'd0, 8'd0));
    runProgram(8'd40, 1'b0);
    runProgram(8'd40, 1'b0);
    runProgram(8'd40, 1'b1);
    count = 0;
    while (!done && count < waitLimit) begin
      @(negedge clock);
      count++;
    end
    checkEqual("done after scene commit", 32'd1, done);
    waitCycles(5);
    checkEqual("done held", 32'd1, done);
    @(negedge clock);
    mst       = 1'b1;
    sceneDone = 1'b0;
    count = 0;
    do begin
      @(negedge clock);
      count++;
    end while (done && count < waitLimit);
    checkEqual("done after mst", 32'd0, done);
    finishTest("commit and done");

    $display("Tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== rtl/controlUnit.sv ====
//--------------------------------------------------------------------------
// Top sequencing FSM for configuration, run, commit and done
// Runs are started by a renderEn rising edge seen in CU_IDLE only
// mst always wins over renderEn
// done holds until mst comes back
//--------------------------------------------------------------------------
`timescale 1ns/10ps

module controlUnit (
  input  logic                                  clock,
  input  logic                                  rstN,
  input  logic                                  mst,          // Host config request
  input  logic                                  renderEn,
  input  logic                                  sceneDone,
  input  logic [theiaPkg::codeAddrWidth-1:0]    entryAddrIn,
  input  logic                                  exeDone,      // One-cycle pulse from EXE
  output logic                                  ioOwnsBus,
  output logic                                  start,
  output logic [theiaPkg::codeAddrWidth-1:0]    entryAddr,
  output logic                                  rCommit,
  output logic                                  done
);

  theiaPkg::cuStateT state;
  logic              renderEnQ;                    // Edge detect copy
  logic              renderRise;

  assign renderRise = renderEn && !renderEnQ;
  assign ioOwnsBus  = (state == theiaPkg::CU_CONFIG);
  assign rCommit    = (state == theiaPkg::CU_COMMIT); // Single cycle state
  assign done       = (state == theiaPkg::CU_DONE);

  //------------------------------------------------------------------------
  // State register
  //------------------------------------------------------------------------
  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      state     <= theiaPkg::CU_IDLE;
      renderEnQ <= 1'b0;
      start     <= 1'b0;
      entryAddr <= '0;
    end else begin
      renderEnQ <= renderEn;
      start     <= 1'b0;
      case (state)
        theiaPkg::CU_IDLE: begin
          if (mst) begin
            state <= theiaPkg::CU_CONFIG;
          end else if (renderRise) begin
            state     <= theiaPkg::CU_RUN;
            entryAddr <= entryAddrIn;                // Latched for the whole run
            start     <= 1'b1;                       // High on first RUN cycle
          end
        end
        theiaPkg::CU_CONFIG: if (!mst) state <= theiaPkg::CU_IDLE;
        theiaPkg::CU_RUN:    if (exeDone) state <= theiaPkg::CU_COMMIT;
        theiaPkg::CU_COMMIT: state <= sceneDone ? theiaPkg::CU_DONE : theiaPkg::CU_IDLE;
        theiaPkg::CU_DONE:   if (mst) state <= theiaPkg::CU_CONFIG;
        default:             state <= theiaPkg::CU_IDLE;
      endcase
    end
  end

  // EXE finishes only inside a run
  exeDoneInRun: assert property (@(posedge clock) disable iff (!rstN)
    exeDone |-> state == theiaPkg::CU_RUN);

endmodule

// ==== rtl/executionUnit.sv ====
//--------------------------------------------------------------------------
// Microcode sequencer with fetch, operand read and execute cycles
// Every instruction takes exactly three cycles with one in flight
// RET ends the run
// The OUT sink must take every request as there is no back-pressure
//--------------------------------------------------------------------------
`timescale 1ns/10ps

module executionUnit (
  input  logic                                  clock,
  input  logic                                  rstN,
  input  logic                                  start,
  input  logic [theiaPkg::codeAddrWidth-1:0]    entryAddr,
  input  logic [theiaPkg::instrWidth-1:0]       instr,
  input  logic [theiaPkg::rowWidth-1:0]         rdData0,      // srcA row
  input  logic [theiaPkg::rowWidth-1:0]         rdData1,      // srcB row
  output logic [theiaPkg::codeAddrWidth-1:0]    ip,
  output logic [theiaPkg::dataAddrWidth-1:0]    rdAddr0,
  output logic [theiaPkg::dataAddrWidth-1:0]    rdAddr1,
  output logic                                  we,
  output logic [theiaPkg::dataAddrWidth-1:0]    wrAddr,
  output logic [theiaPkg::rowWidth-1:0]         wrData,
  output logic                                  outReq,
  output logic [theiaPkg::laneWidth-1:0]        outAddr,
  output logic [theiaPkg::laneWidth-1:0]        outData,
  output logic                                  exeDone
);

  theiaPkg::exeStateT               state;
  theiaPkg::opcodeT                 op;
  logic [theiaPkg::dataAddrWidth-1:0] dst;
  logic [theiaPkg::rowWidth-1:0]    aluRow;
  logic [theiaPkg::codeAddrWidth-1:0] nextIp;
  logic                             isExec;
  logic                             isAlu;
  logic                             takeJump;

  //------------------------------------------------------------------------
  // Decode of instr, stable from READ through EXEC while ip holds
  //------------------------------------------------------------------------
  assign op      = theiaPkg::opcodeT'(instr[theiaPkg::opLsb +: 4]);
  assign dst     = instr[theiaPkg::dstLsb +: theiaPkg::dataAddrWidth];
  assign rdAddr0 = instr[theiaPkg::srcALsb +: theiaPkg::dataAddrWidth];
  assign rdAddr1 = instr[theiaPkg::srcBLsb +: theiaPkg::dataAddrWidth];
  assign isExec  = (state == theiaPkg::EX_EXEC);
  assign isAlu   = (op == theiaPkg::OP_ADD) || (op == theiaPkg::OP_SUB) ||
                   (op == theiaPkg::OP_AND) || (op == theiaPkg::OP_XOR);

  // Lane-wise ALU wrapping modulo 2^32
  for (genvar g = 0; g < theiaPkg::lanes; g++) begin : gAlu
    logic [theiaPkg::laneWidth-1:0] aLane, bLane;
    assign aLane = rdData0[g*theiaPkg::laneWidth +: theiaPkg::laneWidth];
    assign bLane = rdData1[g*theiaPkg::laneWidth +: theiaPkg::laneWidth];
    assign aluRow[g*theiaPkg::laneWidth +: theiaPkg::laneWidth] =
      (op == theiaPkg::OP_ADD) ? aLane + bLane :
      (op == theiaPkg::OP_SUB) ? aLane - bLane :
      (op == theiaPkg::OP_AND) ? aLane & bLane :
                                 aLane ^ bLane;
  end

  // Branch on lane x (lane 0) of srcA
  assign takeJump = (op == theiaPkg::OP_JNZ) &&
                    (rdData0[theiaPkg::laneWidth-1:0] != '0);
  assign nextIp   = takeJump ? dst : ip + 1'b1;

  // Writeback and OUT strobes live only in EXEC
  assign we      = isExec && isAlu;
  assign wrAddr  = dst;
  assign wrData  = aluRow;
  assign outReq  = isExec && (op == theiaPkg::OP_OUT);
  assign outData = rdData0[theiaPkg::laneWidth-1:0];
  assign outAddr = rdData1[theiaPkg::laneWidth-1:0];
  assign exeDone = isExec && (op == theiaPkg::OP_RET);

  //------------------------------------------------------------------------
  // Sequencer
  //------------------------------------------------------------------------
  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      state <= theiaPkg::EX_IDLE;
      ip    <= '0;
    end else begin
      case (state)
        theiaPkg::EX_IDLE: begin
          if (start) begin
            ip    <= entryAddr;
            state <= theiaPkg::EX_FETCH;
          end
        end
        theiaPkg::EX_FETCH: state <= theiaPkg::EX_READ;  // ip on code port
        theiaPkg::EX_READ:  state <= theiaPkg::EX_EXEC;  // Operand rows in flight
        theiaPkg::EX_EXEC: begin
          ip    <= nextIp;
          state <= exeDone ? theiaPkg::EX_IDLE : theiaPkg::EX_FETCH;
        end
        default: state <= theiaPkg::EX_IDLE;
      endcase
    end
  end

  // A start arriving mid-run would be lost
  startWhenIdle: assert property (@(posedge clock) disable iff (!rstN)
    start |-> state == theiaPkg::EX_IDLE);

endmodule

// ==== rtl/ioUnit.sv ====
//--------------------------------------------------------------------------
// Wishbone slave for host load and data readback plus the OMEM write port
// One ack per transfer comes one cycle after the strobe is first seen
// Only data space reads back
// A tgaI of 3 writes nothing and reads zero
//--------------------------------------------------------------------------
`timescale 1ns/10ps

module ioUnit (
  input  logic                                  clock,
  input  logic                                  rstN,
  input  logic                                  ioOwnsBus,
  input  logic [theiaPkg::laneWidth-1:0]        datI,
  input  logic [theiaPkg::busAddrWidth-1:0]     adrI,
  input  logic                                  weI,
  input  logic                                  stbI,
  input  logic                                  cycI,
  input  logic [1:0]                            tgaI,         // Lane select
  output logic [theiaPkg::laneWidth-1:0]        datO,
  output logic                                  ackO,
  output logic                                  codeWe,
  output logic [theiaPkg::codeAddrWidth-1:0]    codeWrAddr,
  output logic [theiaPkg::instrWidth-1:0]       codeWrData,
  output logic                                  dataWe,
  output logic [theiaPkg::dataAddrWidth-1:0]    dataWrAddr,
  output logic [theiaPkg::lanes-1:0]            laneMask,
  output logic [theiaPkg::rowWidth-1:0]         dataWrData,
  output logic [theiaPkg::dataAddrWidth-1:0]    dataRdAddr,
  input  logic [theiaPkg::rowWidth-1:0]         rdData0,
  input  logic                                  outReq,
  input  logic [theiaPkg::laneWidth-1:0]        outAddr,
  input  logic [theiaPkg::laneWidth-1:0]        outData,
  output logic [theiaPkg::laneWidth-1:0]        omemDat,
  output logic [theiaPkg::laneWidth-1:0]        omemAdr,
  output logic                                  omemWe
);

  logic       newXfer;                              // First cycle of a transfer
  logic       inXfer;                               // Acked and waiting for stb drop
  logic       codeSpace;
  logic [1:0] tgaQ;

  assign newXfer   = cycI && stbI && ioOwnsBus && !ackO && !inXfer;
  assign codeSpace = adrI[theiaPkg::codeSpaceBit];

  // Memory side writes go out in the cycle the transfer is seen
  assign codeWe     = newXfer && weI && codeSpace;
  assign codeWrAddr = adrI[theiaPkg::codeAddrWidth-1:0];
  assign codeWrData = datI;
  assign dataWe     = newXfer && weI && !codeSpace;
  assign dataWrAddr = adrI[theiaPkg::dataAddrWidth-1:0];
  assign dataRdAddr = adrI[theiaPkg::dataAddrWidth-1:0];
  assign laneMask   = 3'b001 << tgaI;
  assign dataWrData = {theiaPkg::lanes{datI}};      // Mask picks the lane

  // Read lane lines up with ack after one cycle of RAM latency
  always_comb begin
    case (tgaQ)
      2'd0:    datO = rdData0[0*theiaPkg::laneWidth +: theiaPkg::laneWidth];
      2'd1:    datO = rdData0[1*theiaPkg::laneWidth +: theiaPkg::laneWidth];
      2'd2:    datO = rdData0[2*theiaPkg::laneWidth +: theiaPkg::laneWidth];
      default: datO = '0;
    endcase
  end

  //------------------------------------------------------------------------
  // Ack and output memory control
  //------------------------------------------------------------------------
  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      ackO   <= 1'b0;
      inXfer <= 1'b0;
      tgaQ   <= '0;
      omemWe <= 1'b0;
    end else begin
      ackO   <= newXfer;
      inXfer <= (ackO || inXfer) && cycI && stbI;   // Clears when host lets go
      if (newXfer) tgaQ <= tgaI;
      omemWe <= outReq;
    end
  end

  always_ff @(posedge clock) begin
    if (outReq) begin
      omemDat <= outData;
      omemAdr <= outAddr;
    end
  end

  // Host keeps mst up until the ack
  ackWhileOwned: assert property (@(posedge clock) disable iff (!rstN)
    ackO |-> ioOwnsBus);

endmodule

// ==== rtl/memoryUnit.sv ====
//--------------------------------------------------------------------------
// Instruction RAM plus lane-writable data RAM with two read ports
// All reads are synchronous with one cycle of latency and no bypass
// ioOwnsBus hands read port 0 and the write port to the host side
//--------------------------------------------------------------------------
`timescale 1ns/10ps

module memoryUnit (
  input  logic                                  clock,
  input  logic                                  rstN,
  input  logic                                  ioOwnsBus,
  input  logic [theiaPkg::codeAddrWidth-1:0]    codeRdAddr,
  input  logic                                  codeWe,
  input  logic [theiaPkg::codeAddrWidth-1:0]    codeWrAddr,
  input  logic [theiaPkg::instrWidth-1:0]       codeWrData,
  input  logic [theiaPkg::dataAddrWidth-1:0]    exeRdAddr0,
  input  logic [theiaPkg::dataAddrWidth-1:0]    exeRdAddr1,
  input  logic                                  exeWe,
  input  logic [theiaPkg::dataAddrWidth-1:0]    exeWrAddr,
  input  logic [theiaPkg::rowWidth-1:0]         exeWrData,
  input  logic [theiaPkg::dataAddrWidth-1:0]    ioRdAddr0,
  input  logic                                  ioWe,
  input  logic [theiaPkg::dataAddrWidth-1:0]    ioWrAddr,
  input  logic [theiaPkg::lanes-1:0]            ioLaneMask,
  input  logic [theiaPkg::rowWidth-1:0]         ioWrData,
  output logic [theiaPkg::instrWidth-1:0]       instr,
  output logic [theiaPkg::rowWidth-1:0]         rdData0,
  output logic [theiaPkg::rowWidth-1:0]         rdData1
);

  logic [theiaPkg::instrWidth-1:0]    codeMem [2**theiaPkg::codeAddrWidth];
  logic [theiaPkg::dataAddrWidth-1:0] rdAddr0;
  logic                               wrEn;
  logic [theiaPkg::dataAddrWidth-1:0] wrAddr;
  logic [theiaPkg::lanes-1:0]         wrMask;
  logic [theiaPkg::rowWidth-1:0]      wrRow;

  // Port ownership is decided only here
  assign rdAddr0 = ioOwnsBus ? ioRdAddr0  : exeRdAddr0;
  assign wrEn    = ioOwnsBus ? ioWe       : exeWe;
  assign wrAddr  = ioOwnsBus ? ioWrAddr   : exeWrAddr;
  assign wrMask  = ioOwnsBus ? ioLaneMask : '1;   // EXE writes full rows
  assign wrRow   = ioOwnsBus ? ioWrData   : exeWrData;

  always_ff @(posedge clock) begin
    if (codeWe) codeMem[codeWrAddr] <= codeWrData;
    instr <= codeMem[codeRdAddr];
  end

  // One RAM per lane so a host write touches a single lane
  for (genvar g = 0; g < theiaPkg::lanes; g++) begin : gLane
    logic [theiaPkg::laneWidth-1:0] laneMem [2**theiaPkg::dataAddrWidth];
    logic [theiaPkg::laneWidth-1:0] rd0Lane, rd1Lane;

    always_ff @(posedge clock) begin
      if (wrEn && wrMask[g])
        laneMem[wrAddr] <= wrRow[g*theiaPkg::laneWidth +: theiaPkg::laneWidth];
      rd0Lane <= laneMem[rdAddr0];
      rd1Lane <= laneMem[exeRdAddr1];                // Port 1 is EXE only
    end

    assign rdData0[g*theiaPkg::laneWidth +: theiaPkg::laneWidth] = rd0Lane;
    assign rdData1[g*theiaPkg::laneWidth +: theiaPkg::laneWidth] = rd1Lane;
  end

  // EXE writebacks would be dropped while the host owns the port
  exeWriteNotOwned: assert property (@(posedge clock) disable iff (!rstN)
    exeWe |-> !ioOwnsBus);

endmodule

// ==== rtl/theiaCore.sv ====
//--------------------------------------------------------------------------
// Shader core top: control, memory, execution and I/O units
// Entry address is controlReg[7:0], upper control bits are ignored
//--------------------------------------------------------------------------
`timescale 1ns/10ps

module theiaCore (
  input  logic                                  clock,
  input  logic                                  rstN,
  input  logic                                  mst,          // Host configuration mode
  input  logic [theiaPkg::laneWidth-1:0]        datI,
  input  logic [theiaPkg::busAddrWidth-1:0]     adrI,
  input  logic                                  weI,
  input  logic                                  stbI,
  input  logic                                  cycI,
  input  logic [1:0]                            tgaI,
  input  logic                                  renderEn,
  input  logic                                  sceneDone,
  input  logic [15:0]                           controlReg,
  output logic [theiaPkg::laneWidth-1:0]        datO,
  output logic                                  ackO,
  output logic                                  rCommit,
  output logic                                  done,
  output logic [theiaPkg::laneWidth-1:0]        omemDat,
  output logic [theiaPkg::laneWidth-1:0]        omemAdr,
  output logic                                  omemWe
);

  // Control to the rest
  logic                               ioOwnsBus, start, exeDone;
  logic [theiaPkg::codeAddrWidth-1:0] entryAddr;

  // EXE <-> MEM
  logic [theiaPkg::codeAddrWidth-1:0] ip;
  logic [theiaPkg::instrWidth-1:0]    instr;
  logic [theiaPkg::dataAddrWidth-1:0] exeRdAddr0, exeRdAddr1, exeWrAddr;
  logic                               exeWe;
  logic [theiaPkg::rowWidth-1:0]      exeWrData, rdData0, rdData1;

  // IO <-> MEM, IO <-> EXE
  logic                               codeWe, ioWe;
  logic [theiaPkg::codeAddrWidth-1:0] codeWrAddr;
  logic [theiaPkg::instrWidth-1:0]    codeWrData;
  logic [theiaPkg::dataAddrWidth-1:0] ioWrAddr, ioRdAddr0;
  logic [theiaPkg::lanes-1:0]         ioLaneMask;
  logic [theiaPkg::rowWidth-1:0]      ioWrData;
  logic                               outReq;
  logic [theiaPkg::laneWidth-1:0]     outAddr, outData;

  controlUnit controlUnit_inst (
    .clock, .rstN, .mst, .renderEn, .sceneDone,
    .entryAddrIn (controlReg[theiaPkg::codeAddrWidth-1:0]),
    .exeDone, .ioOwnsBus, .start, .entryAddr, .rCommit, .done
  );

  memoryUnit memoryUnit_inst (
    .clock, .rstN, .ioOwnsBus,
    .codeRdAddr (ip),
    .codeWe, .codeWrAddr, .codeWrData,
    .exeRdAddr0, .exeRdAddr1, .exeWe, .exeWrAddr, .exeWrData,
    .ioRdAddr0, .ioWe, .ioWrAddr, .ioLaneMask, .ioWrData,
    .instr, .rdData0, .rdData1
  );

  executionUnit executionUnit_inst (
    .clock, .rstN, .start, .entryAddr, .instr, .rdData0, .rdData1, .ip,
    .rdAddr0 (exeRdAddr0), .rdAddr1 (exeRdAddr1),
    .we (exeWe), .wrAddr (exeWrAddr), .wrData (exeWrData),
    .outReq, .outAddr, .outData, .exeDone
  );

  ioUnit ioUnit_inst (
    .clock, .rstN, .ioOwnsBus, .datI, .adrI, .weI, .stbI, .cycI, .tgaI,
    .datO, .ackO, .codeWe, .codeWrAddr, .codeWrData,
    .dataWe (ioWe), .dataWrAddr (ioWrAddr), .laneMask (ioLaneMask),
    .dataWrData (ioWrData), .dataRdAddr (ioRdAddr0), .rdData0,
    .outReq, .outAddr, .outData, .omemDat, .omemAdr, .omemWe
  );

endmodule

// ==== rtl/theiaPkg.sv ====
//--------------------------------------------------------------------------
// Shared widths, address map, opcodes and FSM states for the shader core
// Data rows are three 32-bit lanes, both memories hold 256 entries
// Slave address bit 15 picks instruction space, low byte is the row/word
//--------------------------------------------------------------------------
package theiaPkg;

  // Datapath widths
  localparam int laneWidth     = 32;
  localparam int lanes         = 3;
  localparam int rowWidth      = laneWidth * lanes;   // 96
  localparam int dataAddrWidth = 8;                   // 256 rows
  localparam int codeAddrWidth = 8;                   // 256 words
  localparam int instrWidth    = 32;

  // Instruction fields, LSB positions
  localparam int opLsb   = 28;                        // Bits 31..28
  localparam int dstLsb  = 20;                        // Bits 27..20
  localparam int srcALsb = 12;                        // Bits 19..12
  localparam int srcBLsb = 4;                         // Bits 11..4, 3..0 unused

  // Slave bus map
  localparam int busAddrWidth = 16;
  localparam int codeSpaceBit = 15;

  typedef enum logic [3:0] {
    OP_NOP = 4'd0, OP_ADD, OP_SUB, OP_AND,
    OP_XOR, OP_JNZ, OP_OUT, OP_RET
  } opcodeT;

  typedef enum logic [2:0] {
    CU_IDLE, CU_CONFIG, CU_RUN, CU_COMMIT, CU_DONE
  } cuStateT;

  typedef enum logic [1:0] {
    EX_IDLE, EX_FETCH, EX_READ, EX_EXEC
  } exeStateT;

endpackage

// ==== run.sh ====
#!/bin/sh
# Compile the shader core testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module theiaCoreTb -f vlog.f \
  --Mdir obj_dir -o theiaCoreSim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat build.log
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/theiaCoreSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "RESULT: FAIL" sim.log; then
  exit 1
fi
exit 0

// ==== vlog.f ====
rtl/theiaPkg.sv
rtl/controlUnit.sv
rtl/memoryUnit.sv
rtl/executionUnit.sv
rtl/ioUnit.sv
rtl/theiaCore.sv
dv/theiaCoreTb.sv
